//--- source/rom_arb_pkg.sv
package rom_arb_pkg;

  ////////////////////////////////////////
  // Bus and data widths
  ////////////////////////////////////////

  typedef logic [23:0] snes_addr_t; // SNES byte address
  typedef logic [22:0] rom_addr_t;  // ROM word address
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] rom_word_t;
  typedef logic [3:0]  wait_t;

  ////////////////////////////////////////
  // Extra wait cycles per access kind
  ////////////////////////////////////////

  localparam wait_t ROM_RD_WAIT     = 4'd1;
  localparam wait_t ROM_WR_WAIT1    = 4'd3; // Before data capture
  localparam wait_t ROM_WR_WAIT2    = 4'd1; // Write strobe hold
  localparam wait_t ROM_RD_WAIT_MCU = 4'd6;
  localparam wait_t ROM_WR_WAIT_MCU = 4'd5;
  localparam wait_t ROM_RD_WAIT_CX  = 4'd7;

  // Writable save-RAM window
  localparam snes_addr_t SAVE_LO = 24'h700000;
  localparam snes_addr_t SAVE_HI = 24'h77FFFF;

  // Equal samples needed to accept a new strobe level
  localparam int SYNC_DEPTH = 3;

  ////////////////////////////////////////
  // Edge filter lanes
  ////////////////////////////////////////

  localparam int EDGE_RD  = 0;
  localparam int EDGE_WR  = 1;
  localparam int EDGE_CLK = 2;

endpackage

//--- source/bus_edge_filter.sv
`timescale 1ns/10ps

module bus_edge_filter (
  input  logic CLK2,
  input  logic arst_n,
  input  logic level,
  output logic rise,
  output logic fall
);

  localparam int D = rom_arb_pkg::SYNC_DEPTH;

  // Sample history, bit 0 is the newest
  logic [D:0] hist;

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      hist <= '1; // SNES strobes idle high
    end else begin
      hist <= {hist[D-1:0], level};
    end
  end

  ////////////////////////////////////////
  // Edge decode
  ////////////////////////////////////////

  // A new level counts only after D equal samples following the old one,
  // so pulses shorter than D cycles never show up as an edge

  assign rise = ~hist[D] & (&hist[D-1:0]);
  assign fall = hist[D] & ~(|hist[D-1:0]);

endmodule

//--- source/rom_req_latch.sv
`timescale 1ns/10ps

module rom_req_latch (
  input  logic                    CLK2,
  input  logic                    arst_n,
  input  logic                    mcu_rrq,
  input  logic                    mcu_wrq,
  input  rom_arb_pkg::snes_addr_t mcu_addr,
  input  rom_arb_pkg::byte_t      mcu_wdata,
  input  logic                    cx_active,
  input  logic                    cx_rrq,
  input  rom_arb_pkg::snes_addr_t cx_addr,
  input  logic                    mcu_done,
  input  logic                    cx_done,
  output logic                    mcu_pend_rd,
  output logic                    mcu_pend_wr,
  output logic                    cx_pend,
  output rom_arb_pkg::snes_addr_t mcu_addr_q,
  output rom_arb_pkg::byte_t      mcu_wdata_q,
  output rom_arb_pkg::snes_addr_t cx_addr_q,
  output logic                    mcu_rdy,
  output logic                    cx_rdy
);

  ////////////////////////////////////////
  // MCU request
  ////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      mcu_pend_rd <= 1'b0;
      mcu_pend_wr <= 1'b0;
      mcu_rdy     <= 1'b1;
    end else if (mcu_rrq) begin
      mcu_pend_rd <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (mcu_wrq) begin
      mcu_pend_wr <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (mcu_done) begin
      mcu_pend_rd <= 1'b0;
      mcu_pend_wr <= 1'b0;
      mcu_rdy     <= 1'b1; // Read byte already valid
    end
  end

  ////////////////////////////////////////
  // Coprocessor request
  ////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      cx_pend <= 1'b0;
      cx_rdy  <= 1'b1;
    end else if (!cx_active) begin
      cx_pend <= 1'b0; // Drop anything left over
      cx_rdy  <= 1'b1;
    end else if (cx_rrq) begin
      cx_pend <= 1'b1;
      cx_rdy  <= 1'b0;
    end else if (cx_done) begin
      cx_pend <= 1'b0;
      cx_rdy  <= 1'b1;
    end
  end

  // Request payload
  always_ff @(posedge CLK2) begin
    if (mcu_rrq | mcu_wrq) mcu_addr_q <= mcu_addr;
    if (mcu_wrq) mcu_wdata_q <= mcu_wdata;
    if (cx_active & cx_rrq) cx_addr_q <= cx_addr;
  end

endmodule

//--- source/rom_sequencer.sv
`timescale 1ns/10ps

module rom_sequencer #(
  parameter int DEAD_TIMEOUT = 88000
) (
  input  logic                    CLK2,
  input  logic                    arst_n,
  input  rom_arb_pkg::snes_addr_t snes_addr,
  input  rom_arb_pkg::byte_t      snes_data_in,
  input  logic                    snes_wr_n,
  input  logic                    snes_cpu_clk,
  input  logic                    cyc_start,
  input  logic                    cyc_end,
  input  logic                    rd_start,
  input  logic                    rd_end,
  input  logic                    wr_start,
  input  logic                    wr_end,
  input  logic                    cx_active,
  input  logic                    mcu_pend_rd,
  input  logic                    mcu_pend_wr,
  input  logic                    cx_pend,
  input  rom_arb_pkg::snes_addr_t mcu_addr_q,
  input  rom_arb_pkg::byte_t      mcu_wdata_q,
  input  rom_arb_pkg::snes_addr_t cx_addr_q,
  input  rom_arb_pkg::rom_word_t  rom_rdata,
  output rom_arb_pkg::byte_t      snes_data_out,
  output logic                    snes_data_oe,
  output rom_arb_pkg::byte_t      mcu_rdata,
  output rom_arb_pkg::byte_t      cx_rdata,
  output logic                    mcu_done,
  output logic                    cx_done,
  output rom_arb_pkg::rom_addr_t  rom_addr,
  output rom_arb_pkg::rom_word_t  rom_wdata,
  output logic                    rom_wdata_oe,
  output logic                    rom_we_n,
  output logic                    rom_bhe_n,
  output logic                    rom_ble_n
);

  localparam int DEAD_W = $clog2(DEAD_TIMEOUT + 1);

  // One-hot states
  localparam logic [16:0] S_IDLE     = 17'd1 << 0;
  localparam logic [16:0] S_SRD_ADDR = 17'd1 << 1;
  localparam logic [16:0] S_SRD_WAIT = 17'd1 << 2;
  localparam logic [16:0] S_SRD_END  = 17'd1 << 3;
  localparam logic [16:0] S_SWR_ADDR = 17'd1 << 4;
  localparam logic [16:0] S_SWR_WT1  = 17'd1 << 5;
  localparam logic [16:0] S_SWR_WT2  = 17'd1 << 6;
  localparam logic [16:0] S_SWR_END  = 17'd1 << 7;
  localparam logic [16:0] S_MRD_ADDR = 17'd1 << 8;
  localparam logic [16:0] S_MRD_WAIT = 17'd1 << 9;
  localparam logic [16:0] S_MRD_END  = 17'd1 << 10;
  localparam logic [16:0] S_MWR_ADDR = 17'd1 << 11;
  localparam logic [16:0] S_MWR_WAIT = 17'd1 << 12;
  localparam logic [16:0] S_MWR_END  = 17'd1 << 13;
  localparam logic [16:0] S_CRD_ADDR = 17'd1 << 14;
  localparam logic [16:0] S_CRD_WAIT = 17'd1 << 15;
  localparam logic [16:0] S_CRD_END  = 17'd1 << 16;

  logic [16:0]             state;
  rom_arb_pkg::wait_t      dly;
  rom_arb_pkg::snes_addr_t addr_s0, addr_s1, snes_a, sel_addr;
  rom_arb_pkg::byte_t      wbyte, rd_byte;
  logic [DEAD_W-1:0]       dead_cnt;
  logic                    snes_dead, snes_rq, wr_low, rom_sa, rom_ca;
  logic                    dly_zero, in_save, snes_go, cx_go, is_write, abort;

  ////////////////////////////////////////
  // SNES side tracking
  ////////////////////////////////////////

  assign snes_a  = addr_s0 & addr_s1; // Two samples ANDed against bus skew
  assign in_save = (snes_a >= rom_arb_pkg::SAVE_LO) && (snes_a <= rom_arb_pkg::SAVE_HI);

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      snes_data_oe <= 1'b0;
      wr_low       <= 1'b0;
      snes_rq      <= 1'b0;
    end else begin
      if (rd_start) snes_data_oe <= 1'b1;
      else if (rd_end) snes_data_oe <= 1'b0;
      if (wr_start) wr_low <= 1'b1;
      else if (wr_end) wr_low <= 1'b0;
      // Cycle not served before its end is dropped
      snes_rq <= (snes_rq | cyc_start) & ~(state[0] & snes_go & ~cx_go) & ~cyc_end;
    end
  end

  // Dead SNES watchdog, counts cycles with the CPU clock low
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b0;
    end else if (snes_cpu_clk) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b0;
    end else if (dead_cnt == DEAD_W'(DEAD_TIMEOUT)) begin
      snes_dead <= 1'b1;
    end else begin
      dead_cnt <= dead_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // ROM address and data lanes
  ////////////////////////////////////////

  assign sel_addr  = rom_ca ? cx_addr_q : (rom_sa ? snes_a : mcu_addr_q);
  assign rom_addr  = sel_addr[23:1];
  assign rom_ble_n = ~sel_addr[0]; // Odd byte on the low lane
  assign rom_bhe_n = sel_addr[0];
  assign rd_byte   = sel_addr[0] ? rom_rdata[7:0] : rom_rdata[15:8];
  assign rom_wdata = {wbyte, wbyte};

  assign dly_zero = (dly == '0);
  assign cx_go    = cx_active & cx_pend;
  assign snes_go  = cyc_start | snes_rq;
  assign is_write = ~snes_wr_n | wr_low;
  assign abort    = snes_dead & snes_cpu_clk; // SNES back, restart
  assign mcu_done = (state == S_MRD_END) | (state == S_MWR_END);
  assign cx_done  = (state == S_CRD_END);

  ////////////////////////////////////////
  // Access state machine
  ////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      state        <= S_IDLE;
      dly          <= '0;
      rom_we_n     <= 1'b1;
      rom_wdata_oe <= 1'b0;
      rom_sa       <= 1'b1;
      rom_ca       <= 1'b0;
    end else if (abort) begin
      state        <= S_IDLE;
      rom_we_n     <= 1'b1;
      rom_wdata_oe <= 1'b0;
      rom_sa       <= 1'b1;
      rom_ca       <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          rom_sa       <= 1'b1;
          rom_ca       <= 1'b0;
          rom_wdata_oe <= 1'b0;
          if (cx_go) state <= S_CRD_ADDR;
          else if (snes_go & is_write) begin
            state        <= S_SWR_ADDR;
            rom_we_n     <= ~in_save; // Writes outside save RAM are ignored
            rom_wdata_oe <= in_save;
          end
          else if (snes_go) state <= S_SRD_ADDR;
          else if (snes_dead & mcu_pend_rd) state <= S_MRD_ADDR;
          else if (snes_dead & mcu_pend_wr) state <= S_MWR_ADDR;
        end
        S_SRD_ADDR: begin
          dly   <= rom_arb_pkg::ROM_RD_WAIT;
          state <= S_SRD_WAIT;
        end
        S_SRD_WAIT: begin
          dly <= dly - 1'b1;
          if (dly_zero) state <= S_SRD_END;
        end
        S_SWR_ADDR: begin
          dly   <= rom_arb_pkg::ROM_WR_WAIT1;
          state <= S_SWR_WT1;
        end
        S_SWR_WT1: begin
          dly <= dly - 1'b1;
          if (dly_zero) begin
            dly   <= rom_arb_pkg::ROM_WR_WAIT2;
            state <= S_SWR_WT2;
          end
        end
        S_SWR_WT2: begin
          dly <= dly - 1'b1;
          if (dly_zero) begin
            rom_we_n <= 1'b1;
            state    <= S_SWR_END;
          end
        end
        S_SRD_END, S_SWR_END: begin
          rom_wdata_oe <= 1'b0;
          if (mcu_pend_rd) state <= S_MRD_ADDR; // MCU slot after SNES
          else if (mcu_pend_wr) state <= S_MWR_ADDR;
          else state <= S_IDLE;
        end
        S_MRD_ADDR: begin
          rom_sa <= 1'b0;
          dly    <= rom_arb_pkg::ROM_RD_WAIT_MCU;
          state  <= S_MRD_WAIT;
        end
        S_MRD_WAIT: begin
          dly <= dly - 1'b1;
          if (dly_zero) state <= S_MRD_END;
        end
        S_MWR_ADDR: begin
          rom_sa       <= 1'b0;
          rom_we_n     <= 1'b0;
          rom_wdata_oe <= 1'b1;
          dly          <= rom_arb_pkg::ROM_WR_WAIT_MCU;
          state        <= S_MWR_WAIT;
        end
        S_MWR_WAIT: begin
          dly <= dly - 1'b1;
          if (dly_zero) begin
            rom_we_n <= 1'b1;
            state    <= S_MWR_END;
          end
        end
        S_MRD_END, S_MWR_END: begin
          rom_wdata_oe <= 1'b0;
          rom_sa       <= 1'b1;
          state        <= S_IDLE;
        end
        S_CRD_ADDR: begin
          rom_ca <= 1'b1;
          dly    <= rom_arb_pkg::ROM_RD_WAIT_CX;
          state  <= S_CRD_WAIT;
        end
        S_CRD_WAIT: begin
          dly <= dly - 1'b1;
          if (dly_zero) state <= S_CRD_END;
        end
        S_CRD_END: begin
          rom_ca <= 1'b0;
          state  <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Data capture, each byte taken as its wait runs out
  always_ff @(posedge CLK2) begin
    addr_s0 <= snes_addr;
    addr_s1 <= addr_s0;
    if ((state == S_SRD_WAIT) && dly_zero) snes_data_out <= rd_byte;
    if ((state == S_SWR_WT1) && dly_zero) wbyte <= snes_data_in;
    if (state == S_MWR_ADDR) wbyte <= mcu_wdata_q;
    if ((state == S_MRD_WAIT) && dly_zero) mcu_rdata <= rd_byte;
    if ((state == S_CRD_WAIT) && dly_zero) cx_rdata <= rd_byte;
  end

endmodule

//--- source/rom_arb_top.sv
`timescale 1ns/10ps

module rom_arb_top #(
  parameter int DEAD_TIMEOUT = 88000,
  parameter int NUM_EDGES    = 3
) (
  input  logic                    CLK2,
  input  logic                    arst_n,
  // SNES bus
  input  rom_arb_pkg::snes_addr_t snes_addr,
  input  logic                    snes_rd_n,
  input  logic                    snes_wr_n,
  input  logic                    snes_cpu_clk,
  input  rom_arb_pkg::byte_t      snes_data_in,
  output rom_arb_pkg::byte_t      snes_data_out,
  output logic                    snes_data_oe,
  // MCU requests
  input  logic                    mcu_rrq,
  input  logic                    mcu_wrq,
  input  rom_arb_pkg::snes_addr_t mcu_addr,
  input  rom_arb_pkg::byte_t      mcu_wdata,
  output rom_arb_pkg::byte_t      mcu_rdata,
  output logic                    mcu_rdy,
  // Coprocessor requests
  input  logic                    cx_active,
  input  logic                    cx_rrq,
  input  rom_arb_pkg::snes_addr_t cx_addr,
  output rom_arb_pkg::byte_t      cx_rdata,
  output logic                    cx_rdy,
  // ROM pins
  output rom_arb_pkg::rom_addr_t  rom_addr,
  output rom_arb_pkg::rom_word_t  rom_wdata,
  output logic                    rom_wdata_oe,
  output logic                    rom_we_n,
  output logic                    rom_bhe_n,
  output logic                    rom_ble_n,
  input  rom_arb_pkg::rom_word_t  rom_rdata
);

  logic [NUM_EDGES-1:0]    strobe, rise, fall;
  logic                    mcu_pend_rd, mcu_pend_wr, cx_pend, mcu_done, cx_done;
  rom_arb_pkg::snes_addr_t mcu_addr_q, cx_addr_q;
  rom_arb_pkg::byte_t      mcu_wdata_q;

  ////////////////////////////////////////
  // SNES strobe filters
  ////////////////////////////////////////

  assign strobe[rom_arb_pkg::EDGE_RD]  = snes_rd_n;
  assign strobe[rom_arb_pkg::EDGE_WR]  = snes_wr_n;
  assign strobe[rom_arb_pkg::EDGE_CLK] = snes_cpu_clk;

  for (genvar i = 0; i < NUM_EDGES; i++) begin : g_edge
    bus_edge_filter u_flt (
      .CLK2  (CLK2),
      .arst_n(arst_n),
      .level (strobe[i]),
      .rise  (rise[i]),
      .fall  (fall[i])
    );
  end

  rom_req_latch u_req (
    .CLK2       (CLK2),
    .arst_n     (arst_n),
    .mcu_rrq    (mcu_rrq),
    .mcu_wrq    (mcu_wrq),
    .mcu_addr   (mcu_addr),
    .mcu_wdata  (mcu_wdata),
    .cx_active  (cx_active),
    .cx_rrq     (cx_rrq),
    .cx_addr    (cx_addr),
    .mcu_done   (mcu_done),
    .cx_done    (cx_done),
    .mcu_pend_rd(mcu_pend_rd),
    .mcu_pend_wr(mcu_pend_wr),
    .cx_pend    (cx_pend),
    .mcu_addr_q (mcu_addr_q),
    .mcu_wdata_q(mcu_wdata_q),
    .cx_addr_q  (cx_addr_q),
    .mcu_rdy    (mcu_rdy),
    .cx_rdy     (cx_rdy)
  );

  rom_sequencer #(
    .DEAD_TIMEOUT(DEAD_TIMEOUT)
  ) u_seq (
    .CLK2         (CLK2),
    .arst_n       (arst_n),
    .snes_addr    (snes_addr),
    .snes_data_in (snes_data_in),
    .snes_wr_n    (snes_wr_n),
    .snes_cpu_clk (snes_cpu_clk),
    .cyc_start    (rise[rom_arb_pkg::EDGE_CLK]), // Bus cycle begins
    .cyc_end      (fall[rom_arb_pkg::EDGE_CLK]),
    .rd_start     (fall[rom_arb_pkg::EDGE_RD]),
    .rd_end       (rise[rom_arb_pkg::EDGE_RD]),
    .wr_start     (fall[rom_arb_pkg::EDGE_WR]),
    .wr_end       (rise[rom_arb_pkg::EDGE_WR]),
    .cx_active    (cx_active),
    .mcu_pend_rd  (mcu_pend_rd),
    .mcu_pend_wr  (mcu_pend_wr),
    .cx_pend      (cx_pend),
    .mcu_addr_q   (mcu_addr_q),
    .mcu_wdata_q  (mcu_wdata_q),
    .cx_addr_q    (cx_addr_q),
    .rom_rdata    (rom_rdata),
    .snes_data_out(snes_data_out),
    .snes_data_oe (snes_data_oe),
    .mcu_rdata    (mcu_rdata),
    .cx_rdata     (cx_rdata),
    .mcu_done     (mcu_done),
    .cx_done      (cx_done),
    .rom_addr     (rom_addr),
    .rom_wdata    (rom_wdata),
    .rom_wdata_oe (rom_wdata_oe),
    .rom_we_n     (rom_we_n),
    .rom_bhe_n    (rom_bhe_n),
    .rom_ble_n    (rom_ble_n)
  );

endmodule

//--- bench/rom_arb_sva.sv
`timescale 1ns/10ps

module rom_arb_sva (
  input logic                   CLK2,
  input logic                   arst_n,
  input rom_arb_pkg::rom_addr_t rom_addr,
  input logic                   rom_we_n,
  input logic                   rom_wdata_oe,
  input logic                   rom_bhe_n,
  input logic                   rom_ble_n,
  input logic                   mcu_pend_rd,
  input logic                   mcu_pend_wr,
  input logic                   mcu_done
);

  ////////////////////////////////////////
  // ROM strobes
  ////////////////////////////////////////

  // Write strobe only with data driven
  a_we_needs_oe : assert property (@(posedge CLK2) disable iff (!arst_n)
    !rom_we_n |-> rom_wdata_oe)
    else $error("rom_we_n low while rom_wdata_oe is low");

  // Address and byte lane held for the whole write strobe
  a_write_hold : assert property (@(posedge CLK2) disable iff (!arst_n)
    !rom_we_n |=> rom_we_n ||
      ($stable(rom_addr) && $stable(rom_bhe_n) && $stable(rom_ble_n)))
    else $error("ROM address or byte lane moved during a write strobe");

  // Handshake end only for a request still pending
  a_mcu_done_req : assert property (@(posedge CLK2) disable iff (!arst_n)
    mcu_done |-> (mcu_pend_rd || mcu_pend_wr))
    else $error("mcu_done without a pending MCU request");

endmodule

bind rom_sequencer rom_arb_sva u_sva (
  .CLK2        (CLK2),
  .arst_n      (arst_n),
  .rom_addr    (rom_addr),
  .rom_we_n    (rom_we_n),
  .rom_wdata_oe(rom_wdata_oe),
  .rom_bhe_n   (rom_bhe_n),
  .rom_ble_n   (rom_ble_n),
  .mcu_pend_rd (mcu_pend_rd),
  .mcu_pend_wr (mcu_pend_wr),
  .mcu_done    (mcu_done)
);

//--- bench/tb_rom_arb.sv
`timescale 1ns/10ps

module tb_rom_arb;

  localparam int DEAD_CYC = 200;

  logic CLK2, arst_n;
  rom_arb_pkg::snes_addr_t snes_addr, mcu_addr, cx_addr;
  logic snes_rd_n, snes_wr_n, snes_cpu_clk, snes_data_oe;
  rom_arb_pkg::byte_t snes_data_in, snes_data_out, mcu_wdata, mcu_rdata, cx_rdata;
  logic mcu_rrq, mcu_wrq, mcu_rdy, cx_active, cx_rrq, cx_rdy;
  rom_arb_pkg::rom_addr_t rom_addr;
  rom_arb_pkg::rom_word_t rom_wdata, rom_rdata;
  logic rom_wdata_oe, rom_we_n, rom_bhe_n, rom_ble_n;

  int val_errs = 0;
  int other_errs = 0;
  int n_lines = 0;
  int mem_gen = 0;
  logic [31:0] lfsr = 32'hcc15a3a8;
  rom_arb_pkg::rom_word_t rom_mem [rom_arb_pkg::rom_addr_t]; // Written words only

  initial CLK2 = 1'b0;
  always #50 CLK2 = ~CLK2;

  rom_arb_top #(.DEAD_TIMEOUT(DEAD_CYC)) DUT (
    .CLK2(CLK2), .arst_n(arst_n),
    .snes_addr(snes_addr), .snes_rd_n(snes_rd_n), .snes_wr_n(snes_wr_n),
    .snes_cpu_clk(snes_cpu_clk), .snes_data_in(snes_data_in),
    .snes_data_out(snes_data_out), .snes_data_oe(snes_data_oe),
    .mcu_rrq(mcu_rrq), .mcu_wrq(mcu_wrq), .mcu_addr(mcu_addr), .mcu_wdata(mcu_wdata),
    .mcu_rdata(mcu_rdata), .mcu_rdy(mcu_rdy),
    .cx_active(cx_active), .cx_rrq(cx_rrq), .cx_addr(cx_addr),
    .cx_rdata(cx_rdata), .cx_rdy(cx_rdy),
    .rom_addr(rom_addr), .rom_wdata(rom_wdata), .rom_wdata_oe(rom_wdata_oe),
    .rom_we_n(rom_we_n), .rom_bhe_n(rom_bhe_n), .rom_ble_n(rom_ble_n),
    .rom_rdata(rom_rdata)
  );

  ////////////////////////////////////////
  // ROM model
  ////////////////////////////////////////

  function automatic rom_arb_pkg::rom_word_t model_read(rom_arb_pkg::rom_addr_t a);
    if (rom_mem.exists(a)) return rom_mem[a];
    return {a[7:0] ^ {1'b0, a[22:16]}, a[15:8] ^ 8'ha5}; // Unwritten fill
  endfunction

  always @(rom_addr or mem_gen) rom_rdata = model_read(rom_addr);

  always @(negedge CLK2) begin : rom_write
    rom_arb_pkg::rom_word_t w;
    if (arst_n && !rom_we_n) begin
      w = model_read(rom_addr);
      if (!rom_bhe_n) w[15:8] = rom_wdata[15:8];
      if (!rom_ble_n) w[7:0] = rom_wdata[7:0];
      rom_mem[rom_addr] = w;
      mem_gen++;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32 22 2 1
  endfunction

  task automatic tick(int n);
    repeat (n) @(posedge CLK2);
    #1;
  endtask

  task automatic random_gap();
    int n;
    n = 0;
    repeat (3) begin
      lfsr = lfsr_step(lfsr);
      n = (n << 1) | lfsr[0];
    end
    tick(n + 1);
  endtask

  task automatic check_byte(string name, rom_arb_pkg::byte_t exp, rom_arb_pkg::byte_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      val_errs++;
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      val_errs++;
    end
  endtask

  // One SNES bus cycle, 8 cycles per clock phase
  task automatic snes_cycle(rom_arb_pkg::snes_addr_t a, logic wr, rom_arb_pkg::byte_t d,
                            output rom_arb_pkg::byte_t rd, output logic oe);
    snes_addr    = a;
    snes_data_in = d;
    snes_rd_n    = wr;
    snes_wr_n    = ~wr;
    snes_cpu_clk = 1'b0;
    tick(8);
    snes_cpu_clk = 1'b1;
    tick(8);
    snes_cpu_clk = 1'b0;
    tick(8);
    rd = snes_data_out; // Read strobe still low here
    oe = snes_data_oe;
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
  endtask

  task automatic mcu_access(string name, logic wr, rom_arb_pkg::snes_addr_t a,
                            rom_arb_pkg::byte_t d, logic bg);
    rom_arb_pkg::byte_t rd;
    logic oe;
    int n;
    random_gap();
    mcu_addr  = a;
    mcu_wdata = d;
    mcu_rrq   = ~wr;
    mcu_wrq   = wr;
    tick(1);
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    tick(1);
    n = 0;
    while (!mcu_rdy && n < 40) begin
      if (bg) snes_cycle(24'h000000, 1'b0, 8'h00, rd, oe); // Background SNES reads
      else tick(1);
      n++;
    end
    if (!mcu_rdy) begin
      $display("Timeout: MCU request in %s never completed", name);
      other_errs++;
    end
  endtask

  task automatic cx_read(string name, rom_arb_pkg::snes_addr_t a, rom_arb_pkg::byte_t exp);
    int n;
    cx_active = 1'b1;
    random_gap();
    cx_addr = a;
    cx_rrq  = 1'b1;
    tick(1);
    cx_rrq = 1'b0;
    tick(1);
    n = 0;
    while (!cx_rdy && n < 60) begin
      tick(1);
      n++;
    end
    if (!cx_rdy) begin
      $display("Timeout: coprocessor read in %s never completed", name);
      other_errs++;
    end
    check_byte(name, exp, cx_rdata);
    // Requests while inactive are ignored
    cx_active = 1'b0;
    tick(2);
    cx_rrq = 1'b1;
    tick(1);
    cx_rrq = 1'b0;
    repeat (4) begin
      check_flag({name, " inactive cx_rdy"}, 1'b1, cx_rdy);
      tick(1);
    end
  endtask

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  initial begin
    @(posedge arst_n); // Line count known by now
    repeat (n_lines * 400) @(posedge CLK2);
    $display("Watchdog: simulation did not finish in the allowed time");
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int fd, code, ln;
    string line, name;
    logic [63:0] op;
    logic [31:0] addr, wd, ex;
    rom_arb_pkg::byte_t rd;
    logic oe;
    arst_n = 1'b0;
    snes_addr = '0;
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
    snes_cpu_clk = 1'b0;
    snes_data_in = '0;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    mcu_addr = '0;
    mcu_wdata = '0;
    cx_active = 1'b0;
    cx_rrq = 1'b0;
    cx_addr = '0;
    fd = $fopen("bench/rom_arb_stim.txt", "r");
    if (fd == 0) begin
      $display("Stimulus file bench/rom_arb_stim.txt could not be opened");
      other_errs++;
      n_lines = 1;
    end else begin
      while ($fgets(line, fd)) begin
        if ($sscanf(line, "%s %h %h %h", op, addr, wd, ex) == 4) n_lines++;
      end
      $fclose(fd);
      if (n_lines == 0) begin
        $display("Stimulus file holds no operations");
        other_errs++;
        n_lines = 1;
      end
    end
    repeat (3) @(posedge CLK2);
    #1 arst_n = 1'b1;
    tick(1);
    check_flag("reset mcu_rdy", 1'b1, mcu_rdy);
    check_flag("reset cx_rdy", 1'b1, cx_rdy);
    check_flag("reset rom_we_n", 1'b1, rom_we_n);
    check_flag("reset rom_wdata_oe", 1'b0, rom_wdata_oe);
    check_flag("reset snes_data_oe", 1'b0, snes_data_oe);
    fd = (other_errs == 0) ? $fopen("bench/rom_arb_stim.txt", "r") : 0;
    ln = 0;
    while (fd != 0 && $fgets(line, fd)) begin
      ln++;
      code = $sscanf(line, "%s %h %h %h", op, addr, wd, ex);
      if (code == 4) begin
        name = $sformatf("%0s line %0d", op, ln);
        case (op)
          "SR": begin
            snes_cycle(addr[23:0], 1'b0, 8'h00, rd, oe);
            check_byte(name, ex[7:0], rd);
            check_flag({name, " snes_data_oe"}, 1'b1, oe);
          end
          "SW": snes_cycle(addr[23:0], 1'b1, wd[7:0], rd, oe);
          "MR": begin
            mcu_access(name, 1'b0, addr[23:0], 8'h00, 1'b1);
            check_byte(name, ex[7:0], mcu_rdata);
          end
          "MW": mcu_access(name, 1'b1, addr[23:0], wd[7:0], 1'b1);
          "CR": cx_read(name, addr[23:0], ex[7:0]);
          "DEAD": begin
            snes_cpu_clk = 1'b0;
            tick(DEAD_CYC + 20); // SNES now dead
            mcu_access(name, 1'b1, addr[23:0], wd[7:0], 1'b0);
            check_flag({name, " write mcu_rdy"}, 1'b1, mcu_rdy);
            mcu_access(name, 1'b0, addr[23:0], 8'h00, 1'b0);
            check_byte(name, ex[7:0], mcu_rdata);
          end
          default: begin
            $display("Unknown operation on stimulus line %0d", ln);
            other_errs++;
          end
        endcase
      end
    end
    if (fd != 0) $fclose(fd);
    tick(4);
    $display("Errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
    if (val_errs + other_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- bench/rom_arb_stim.txt
# op  snes or mcu address  write data  expected byte
# ops are SR SW MR MW CR DEAD, all numbers in hex
SR 001235 00 AC
SR 012344 00 A2
SR 400002 00 21
SW 700010 5C 00
SR 700010 00 5C
SR 700011 00 A5
SW 700021 3E 00
SR 700021 00 3E
SW 000100 77 00
SR 000100 00 80
MR 001235 00 AC
MR 700010 00 5C
MW 001000 4D 00
MR 001000 00 4D
CR 012345 00 34
DEAD 200400 99 99
SR 200400 00 99
MR 400002 00 21

//--- tb.f
source/rom_arb_pkg.sv
source/bus_edge_filter.sv
source/rom_req_latch.sv
source/rom_sequencer.sv
source/rom_arb_top.sv
bench/rom_arb_sva.sv
bench/tb_rom_arb.sv
